/* routerOutPort.f */
nocPkg.sv
flitPortIf.sv
flitDecode.sv
grantTimer.sv
switchArbiter.sv
outputStage.sv
routerOutPort.sv
routerOutPort_assertions.sv
routerOutPort_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and judge the result from the log

rm -f sim.log
verilator --binary --timing --assert -f routerOutPort.f --top-module routerOutPort_tb \
  -o simv > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log && exit 0 || exit 1

/* routerOutPort_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module routerOutPort_tb;

  typedef struct packed {
    int port;
    int numFlits;
    int lenField;  // Length written into the head, may differ from numFlits
    int start;
    bit bp;        // Random outReady from this row on
    bit chkLat;
  } pktRow_t;

  localparam int numRows = 13;

  // Single packet, five at once, budget preemption, then back-pressure
  localparam pktRow_t pktTable [numRows] = '{
    '{0, 4, 4,  2, 1'b0, 1'b1},
    '{0, 3, 3, 20, 1'b0, 1'b0},
    '{1, 2, 2, 20, 1'b0, 1'b0},
    '{2, 4, 4, 20, 1'b0, 1'b0},
    '{3, 2, 2, 20, 1'b0, 1'b0},
    '{4, 3, 3, 20, 1'b0, 1'b0},
    '{0, 5, 2, 50, 1'b0, 1'b0},
    '{1, 3, 3, 50, 1'b0, 1'b0},
    '{0, 6, 6, 80, 1'b1, 1'b0},
    '{1, 5, 5, 82, 1'b1, 1'b0},
    '{2, 4, 4, 84, 1'b1, 1'b0},
    '{3, 3, 3, 86, 1'b1, 1'b0},
    '{4, 5, 5, 88, 1'b1, 1'b0}
  };

  // Whole packets in priority order, then L cut after its two-flit budget
  localparam int allAtOnceOrder [14] = '{0, 0, 0, 1, 1, 2, 2, 2, 2, 3, 3, 4, 4, 4};
  localparam int preemptOrder [8]    = '{0, 0, 1, 1, 1, 0, 0, 0};

  logic        clk;
  logic        rst;
  logic [4:0]  inValid;
  logic [31:0] inFlit [5];
  logic [2:0]  inFlitId [5];
  logic [4:0]  inReady;
  logic        outValid;
  logic [31:0] outFlit;
  logic [2:0]  outFlitId;
  logic [2:0]  outPort;
  logic        outReady;

  logic [31:0] pendFlit [5][$];
  logic [2:0]  pendId [5][$];
  logic [31:0] expFlit [5][$];
  logic [2:0]  expId [5][$];
  int          expCyc [5][$];
  int          seenAllAtOnce [$];
  int          seenPreempt [$];
  logic [4:0]  fired;
  logic [31:0] rngState;
  logic        bpMode;
  int          cyc;
  int          timeoutLimit;
  int          lastStart;
  logic        finished;

  routerOutPort dut
  (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .inFlit    (inFlit),
    .inFlitId  (inFlitId),
    .inReady   (inReady),
    .outValid  (outValid),
    .outFlit   (outFlit),
    .outFlitId (outFlitId),
    .outPort   (outPort),
    .outReady  (outReady)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #4 clk = ~clk;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
      failRun("Output does not match the expected value");
    end
  endtask

  // Builds the flits of one packet and queues them for the driver and the scoreboard
  task automatic loadPacket(input int r);
    pktRow_t     row;
    logic [31:0] word;
    logic [2:0]  id;
    row = pktTable[r];
    for (int k = 0; k < row.numFlits; k++)
    begin
      if (k == 0)
      begin
        word = {8'(row.port * 16 + r), 12'(row.lenField), 12'(r)};
        id   = 3'd1;
      end
      else
      begin
        rngState = xorshift32(rngState);
        word     = rngState;
        id       = (k == row.numFlits - 1) ? 3'd3 : 3'd2;
      end
      pendFlit[row.port].push_back(word);
      pendId[row.port].push_back(id);
      expFlit[row.port].push_back(word);
      expId[row.port].push_back(id);
      expCyc[row.port].push_back(row.chkLat ? row.start + 2 + k : -1);
    end
  endtask

  // Every flit has entered the router and the output register is empty
  function automatic logic inputsIdle();
    logic empty;
    empty = 1'b1;
    for (int i = 0; i < 5; i++)
    begin
      if (pendFlit[i].size() != 0)
      begin
        empty = 1'b0;
      end
    end
    return empty && !outValid;
  endfunction

  function automatic logic scoreboardEmpty();
    logic empty;
    empty = 1'b1;
    for (int i = 0; i < 5; i++)
    begin
      if (expFlit[i].size() != 0)
      begin
        empty = 1'b0;
      end
    end
    return empty;
  endfunction

  always @(posedge clk)
  begin
    fired <= inValid & inReady;
  end

  // Scoreboard, one expected queue per source port
  always @(posedge clk)
  begin
    int p;
    if (!rst && outValid && outReady)
    begin
      p = int'(outPort);
      assert (p < 5 && expFlit[p].size() > 0)
      else
      begin
        failRun("A flit left the router that no port had sent");
      end
      checkValue("outFlit", outFlit, expFlit[p].pop_front());
      checkValue("outFlitId", {29'd0, outFlitId}, {29'd0, expId[p].pop_front()});
      if (expCyc[p][0] >= 0)
      begin
        checkValue("output cycle", cyc, expCyc[p][0]);
      end
      void'(expCyc[p].pop_front());
      if (cyc >= 20 && cyc < 50)
      begin
        seenAllAtOnce.push_back(p);
      end
      else if (cyc >= 50 && cyc < 80)
      begin
        seenPreempt.push_back(p);
      end
    end
  end

  initial
  begin
    rst      = 1'b1;
    inValid  = '0;
    outReady = 1'b1;
    for (int i = 0; i < 5; i++)
    begin
      inFlit[i]   = '0;
      inFlitId[i] = '0;
    end
    rngState     = 32'd7483;
    bpMode       = 1'b0;
    cyc          = 0;
    finished     = 1'b0;
    timeoutLimit = 200;
    lastStart    = 0;
    for (int r = 0; r < numRows; r++)
    begin
      timeoutLimit += 4 * pktTable[r].numFlits;
      if (pktTable[r].start > lastStart)
      begin
        lastStart = pktTable[r].start;
      end
    end

    repeat (2) @(posedge clk);
    @(negedge clk);
    checkValue("outValid in reset", {31'd0, outValid}, 32'd0);
    checkValue("inReady in reset", {27'd0, inReady}, 32'd0);
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    checkValue("outValid after reset", {31'd0, outValid}, 32'd0);
    checkValue("inReady after reset", {27'd0, inReady}, 32'd0);

    while (!finished)
    begin
      @(negedge clk);
      cyc++;
      if (cyc > timeoutLimit)
      begin
        failRun("Timeout: the router stopped delivering flits");
      end
      for (int i = 0; i < 5; i++)
      begin
        if (fired[i])
        begin
          void'(pendFlit[i].pop_front());
          void'(pendId[i].pop_front());
        end
      end
      for (int r = 0; r < numRows; r++)
      begin
        if (pktTable[r].start == cyc)
        begin
          loadPacket(r);
          if (pktTable[r].bp)
          begin
            bpMode = 1'b1;
          end
        end
      end
      for (int i = 0; i < 5; i++)
      begin
        inValid[i]  = (pendFlit[i].size() != 0);
        inFlit[i]   = inValid[i] ? pendFlit[i][0] : 32'd0;
        inFlitId[i] = inValid[i] ? pendId[i][0] : 3'd0;
      end
      if (bpMode)
      begin
        rngState = xorshift32(rngState);
        outReady = rngState[3];
      end
      else
      begin
        outReady = 1'b1;
      end
      finished = (cyc > lastStart) && inputsIdle();
    end

    checkValue("packets seen at once", seenAllAtOnce.size(), 14);
    for (int j = 0; j < 14; j++)
    begin
      checkValue("outPort order at once", seenAllAtOnce[j], allAtOnceOrder[j]);
    end
    checkValue("packets seen in preemption", seenPreempt.size(), 8);
    for (int j = 0; j < 8; j++)
    begin
      checkValue("outPort order in preemption", seenPreempt[j], preemptOrder[j]);
    end

    if (scoreboardEmpty())
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Flits entered the router but never left it");
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* routerOutPort_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module routerOutPort_assertions
(
  input wire logic        clk,
  input wire logic        rst,
  input wire logic [4:0]  grant,
  input wire logic [4:0]  ready,
  input wire logic        outValid,
  input wire logic [31:0] outFlit,
  input wire logic        outReady
);

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant has more than one bit set");

  singleReady: assert property (@(posedge clk) disable iff (rst) $onehot0(ready))
    else $error("more than one input is ready");

  // A stalled output keeps its word until the link takes it
  stallStable: assert property (@(posedge clk) disable iff (rst)
    (outValid && !outReady) |=> (outValid && $stable(outFlit)))
    else $error("outFlit changed while stalled");

endmodule

bind outputStage routerOutPort_assertions checkInst
(
  .clk      (clk),
  .rst      (rst),
  .grant    (grant),
  .ready    ({ports[4].ready, ports[3].ready, ports[2].ready, ports[1].ready, ports[0].ready}),
  .outValid (outValid),
  .outFlit  (outFlit),
  .outReady (outReady)
);

`default_nettype wire

/* routerOutPort.sv */
`timescale 1ns/100ps
`default_nettype none

module routerOutPort
(
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic [nocPkg::numPorts-1:0] inValid,
  input  wire logic [nocPkg::flitWidth-1:0] inFlit [nocPkg::numPorts],
  input  wire logic [nocPkg::idWidth-1:0]  inFlitId [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0]      inReady,
  output logic                             outValid,
  output logic [nocPkg::flitWidth-1:0]     outFlit,
  output logic [nocPkg::idWidth-1:0]       outFlitId,
  output logic [2:0]                       outPort,
  input  wire logic                        outReady
);

  logic [nocPkg::numPorts-1:0] grant;

  // One bundle per input, indexed L, N, E, W, S
  flitPortIf portBus [nocPkg::numPorts] ();

  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : genDecode
    flitDecode decodeInst
    (
      .clk    (clk),
      .rst    (rst),
      .valid  (inValid[i]),
      .flit   (inFlit[i]),
      .flitId (inFlitId[i]),
      .ready  (inReady[i]),
      .port   (portBus[i])
    );
  end

  switchArbiter arbInst
  (
    .clk   (clk),
    .rst   (rst),
    .ports (portBus),
    .grant (grant)
  );

  outputStage outInst
  (
    .clk       (clk),
    .rst       (rst),
    .grant     (grant),
    .ports     (portBus),
    .outValid  (outValid),
    .outFlit   (outFlit),
    .outFlitId (outFlitId),
    .outPort   (outPort),
    .outReady  (outReady)
  );

endmodule

`default_nettype wire

/* outputStage.sv */
`timescale 1ns/100ps
`default_nettype none

module outputStage
(
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic [nocPkg::numPorts-1:0] grant,
  flitPortIf.sink                          ports [nocPkg::numPorts],
  output logic                             outValid,
  output logic [nocPkg::flitWidth-1:0]     outFlit,
  output logic [nocPkg::idWidth-1:0]       outFlitId,
  output logic [2:0]                       outPort,
  input  wire logic                        outReady
);

  nocPkg::flitWord_t           flitIn [nocPkg::numPorts];
  logic [nocPkg::idWidth-1:0]  idIn [nocPkg::numPorts];
  logic [nocPkg::numPorts-1:0] present;
  logic                        canLoad;
  logic                        take;
  nocPkg::flitWord_t           selFlit;
  logic [nocPkg::idWidth-1:0]  selId;
  logic [2:0]                  selPort;

  assign canLoad = !outValid || outReady;  // Register empty or draining this cycle

  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : genSink
    assign flitIn[i]      = ports[i].flit;
    assign idIn[i]        = ports[i].flitId;
    assign present[i]     = (idIn[i] != nocPkg::flitNone);
    assign ports[i].ready = grant[i] && canLoad;
  end

  always_comb
  begin
    selFlit = '0;
    selId   = nocPkg::flitNone;
    selPort = nocPkg::portL;
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      if (grant[i])
      begin
        selFlit = flitIn[i];
        selId   = idIn[i];
        selPort = nocPkg::portCode[i];
      end
    end
  end

  assign take = canLoad && |(grant & present);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else if (canLoad)
    begin
      outValid <= take;
    end
  end

  // Contents stay put while the link stalls
  always_ff @(posedge clk)
  begin
    if (take)
    begin
      outFlit   <= selFlit.payload;
      outFlitId <= selId;
      outPort   <= selPort;
    end
  end

endmodule

`default_nettype wire

/* switchArbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module switchArbiter
(
  input  wire logic                    clk,
  input  wire logic                    rst,
  flitPortIf.arb                       ports [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0]  grant
);

  // One-hot state, bit 0 is idle and bit i+1 means port i owns the link
  logic [nocPkg::numPorts:0]   state;
  logic [nocPkg::numPorts:0]   nextState;
  logic [nocPkg::numPorts-1:0] reqVec;
  logic [nocPkg::numPorts-1:0] runTimer;
  logic [nocPkg::numPorts-1:0] timesUp;
  logic [nocPkg::numPorts-1:0] pick;
  logic [nocPkg::lenWidth-1:0] limitVec [nocPkg::numPorts];
  int                          owner;

  // First requester at or after start, wrapping round the ports
  function automatic logic [nocPkg::numPorts-1:0] pickFrom
  (
    input logic [nocPkg::numPorts-1:0] reqs,
    input int                          start
  );
    logic [nocPkg::numPorts-1:0] found;
    logic                        done;
    int                          idx;
    found = '0;
    done  = 1'b0;
    for (int k = 0; k < nocPkg::numPorts; k++)
    begin
      idx = (start + k) % nocPkg::numPorts;
      if (!done && reqs[idx])
      begin
        found[idx] = 1'b1;
        done       = 1'b1;
      end
    end
    return found;
  endfunction

  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : genTimer
    assign reqVec[i]   = ports[i].req;
    assign limitVec[i] = ports[i].limit;

    grantTimer timerInst
    (
      .clk      (clk),
      .rst      (rst),
      .runTimer (runTimer[i]),
      .limit    (limitVec[i]),
      .timesUp  (timesUp[i])
    );
  end

  assign grant = state[nocPkg::numPorts:1];

  always_comb
  begin
    owner = 0;
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      if (grant[i])
      begin
        owner = i;
      end
    end
  end

  always_comb
  begin
    runTimer = '0;
    if (state[0])
    begin
      pick = pickFrom(reqVec, 0);  // Fixed order L, N, E, W, S out of idle
    end
    else if (reqVec[owner] && !timesUp[owner])
    begin
      pick             = grant;
      runTimer[owner]  = 1'b1;
    end
    else
    begin
      // Owner comes last in the search, so a lone requester is granted again
      pick = pickFrom(reqVec, owner + 1);
    end
  end

  assign nextState = {pick, (pick == '0)};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= {{nocPkg::numPorts{1'b0}}, 1'b1};
    end
    else
    begin
      state <= nextState;
    end
  end

endmodule

`default_nettype wire

/* grantTimer.sv */
`timescale 1ns/100ps
`default_nettype none

module grantTimer
(
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic                        runTimer,
  input  wire logic [nocPkg::lenWidth-1:0] limit,
  output logic                             timesUp
);

  // Number of the grant cycle in progress, so the first owned cycle reads one
  logic [nocPkg::lenWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= 12'd1;
    end
    else if (!runTimer)
    begin
      count <= 12'd1;  // Any pause in the grant restarts the budget
    end
    else
    begin
      count <= count + 12'd1;
    end
  end

  // A zero budget still allows the single cycle already granted
  assign timesUp = (count >= limit);

endmodule

`default_nettype wire

/* flitDecode.sv */
`timescale 1ns/100ps
`default_nettype none

module flitDecode
(
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic                       valid,
  input  wire nocPkg::flitWord_t          flit,
  input  wire logic [nocPkg::idWidth-1:0] flitId,
  output logic                            ready,
  flitPortIf.decode                       port
);

  logic [nocPkg::lenWidth-1:0] budget;
  logic                        headSeen;

  assign headSeen = valid && (flitId == nocPkg::flitHead);

  assign port.req  = valid;
  assign port.flit = flit;
  assign ready     = port.ready;

  // The sink treats a zero type as an empty slot
  assign port.flitId = valid ? flitId : nocPkg::flitNone;

  // Packet length of the latest head becomes the grant budget
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
    end
    else if (headSeen)
    begin
      budget <= flit.head.length;
    end
  end

  assign port.limit = budget;

endmodule

`default_nettype wire

/* flitPortIf.sv */
`timescale 1ns/100ps
`default_nettype none

interface flitPortIf;

  logic                           req;
  nocPkg::flitWord_t              flit;
  logic [nocPkg::idWidth-1:0]     flitId;  // flitNone while the port is not valid
  logic [nocPkg::lenWidth-1:0]    limit;
  logic                           ready;

  modport decode
  (
    output req,
    output flit,
    output flitId,
    output limit,
    input  ready
  );

  modport arb
  (
    input req,
    input limit
  );

  modport sink
  (
    input  flit,
    input  flitId,
    output ready
  );

endinterface

`default_nettype wire

/* nocPkg.sv */
`default_nettype none

package nocPkg;

  localparam int numPorts  = 5;
  localparam int flitWidth = 32;
  localparam int idWidth   = 3;
  localparam int lenWidth  = 12;

  // Source indices reported on outPort
  localparam logic [2:0] portL = 3'd0;
  localparam logic [2:0] portN = 3'd1;
  localparam logic [2:0] portE = 3'd2;
  localparam logic [2:0] portW = 3'd3;
  localparam logic [2:0] portS = 3'd4;

  // Index table in port order L, N, E, W, S
  localparam logic [2:0] portCode [numPorts] = '{portL, portN, portE, portW, portS};

  localparam logic [idWidth-1:0] flitNone = 3'd0;
  localparam logic [idWidth-1:0] flitHead = 3'd1;
  localparam logic [idWidth-1:0] flitBody = 3'd2;
  localparam logic [idWidth-1:0] flitTail = 3'd3;

  typedef struct packed {
    logic [7:0]          dest;   // Carried only, no routing here
    logic [lenWidth-1:0] length;
    logic [11:0]         spare;
  } headFields_t;

  // Head flits carry the header fields, body and tail flits carry plain data
  typedef union packed {
    headFields_t          head;
    logic [flitWidth-1:0] payload;
  } flitWord_t;

endpackage

`default_nettype wire
